//--- hdl/aes_cfg.svh
`ifndef AES_CFG_SVH
`define AES_CFG_SVH

// Width of the block count register and counter
`define AES_BLKCNT_W 8

// Register map, word offsets on the host register bus
`define AES_REG_SRC    32'd0
`define AES_REG_DST    32'd1
`define AES_REG_NBLK   32'd2
`define AES_REG_KEY0   32'd3
`define AES_REG_KEY1   32'd4
`define AES_REG_KEY2   32'd5
`define AES_REG_KEY3   32'd6
`define AES_REG_CMD    32'd7
`define AES_REG_STATUS 32'd8

`endif

//--- hdl/aes_engine.sv
`default_nettype none

module aes_engine import aes_pkg::*; (
  input  logic   clk,
  input  logic   reset_n,
  input  block_t key_i,
  input  logic   key_load_i,
  input  logic   load_en_i,
  input  widx_t  load_idx_i,
  input  word_t  load_data_i,
  input  logic   run_i,
  output logic   done_o,
  output logic   busy_o,
  input  widx_t  out_idx_i,
  output word_t  out_word_o
);

  block_t     buf_q;
  block_t     buf_d;
  block_t     key_q;
  block_t     st_q;
  block_t     rk_q;
  logic [7:0] rcon_q;
  round_t     rnd_q;
  logic       busy_q;
  logic       done_q;

  logic [7:0] sub_b [16];
  logic [7:0] shf_b [16];
  logic [7:0] mix_b [16];
  word_t      kw_sub;
  block_t     rk_next;
  block_t     round_out;

  // Word 0 sits in the top 32 bits
  always_comb begin
    buf_d = buf_q;
    if (load_en_i) begin
      buf_d[{~load_idx_i, 5'b00000} +: 32] = load_data_i;
    end
  end

  // Byte n of the state is row n%4, column n/4
  always_comb begin
    for (int n = 0; n < 16; n++) begin
      sub_b[n] = aes_sbox(st_q[127 - 8 * n -: 8]);
    end
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shf_b[4 * c + r] = sub_b[4 * ((c + r) % 4) + r];
      end
    end
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        mix_b[4 * c + r] = aes_xtime(shf_b[4 * c + r]) ^
                           aes_xtime(shf_b[4 * c + (r + 1) % 4]) ^
                           shf_b[4 * c + (r + 1) % 4] ^
                           shf_b[4 * c + (r + 2) % 4] ^
                           shf_b[4 * c + (r + 3) % 4];
      end
    end
  end

  // Next round key, RotWord then SubWord on the last word
  always_comb begin
    kw_sub = {aes_sbox(rk_q[23:16]), aes_sbox(rk_q[15:8]),
              aes_sbox(rk_q[7:0]), aes_sbox(rk_q[31:24])};
    rk_next[127:96] = rk_q[127:96] ^ kw_sub ^ {rcon_q, 24'd0};
    rk_next[95:64]  = rk_q[95:64] ^ rk_next[127:96];
    rk_next[63:32]  = rk_q[63:32] ^ rk_next[95:64];
    rk_next[31:0]   = rk_q[31:0] ^ rk_next[63:32];
  end

  // No MixColumns in the final round
  always_comb begin
    for (int n = 0; n < 16; n++) begin
      round_out[127 - 8 * n -: 8] = (rnd_q == 4'd10) ? shf_b[n] : mix_b[n];
    end
    round_out = round_out ^ rk_next;
  end

  always_ff @(posedge clk) begin
    buf_q <= buf_d;
    if (key_load_i) begin
      key_q <= key_i;
    end
    // Initial AddRoundKey happens as the run is taken
    if (run_i) begin
      st_q   <= buf_d ^ key_q;
      rk_q   <= key_q;
      rcon_q <= 8'h01;
    end else if (busy_q) begin
      st_q   <= round_out;
      rk_q   <= rk_next;
      rcon_q <= aes_xtime(rcon_q);
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      rnd_q  <= '0;
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else if (run_i) begin
      rnd_q  <= 4'd1;
      busy_q <= 1'b1;
      done_q <= 1'b0;
    end else if (busy_q) begin
      rnd_q  <= rnd_q + 1'b1;
      busy_q <= (rnd_q != 4'd10);
      done_q <= (rnd_q == 4'd10);
    end else begin
      done_q <= 1'b0;
    end
  end

  assign done_o     = done_q;
  assign busy_o     = busy_q;
  assign out_word_o = st_q[{~out_idx_i, 5'b00000} +: 32];

endmodule

`default_nettype wire

//--- hdl/aes_fsm.sv
`default_nettype none

module aes_fsm import aes_pkg::*; (
  input  logic    clk,
  input  logic    reset_n,
  input  logic    start_i,
  input  word_t   src_addr_i,
  input  word_t   dst_addr_i,
  input  blkcnt_t nblk_i,
  output logic    busy_o,
  output logic    event_o,
  output logic    src_start_o,
  output logic    snk_start_o,
  output word_t   xfer_addr_o,
  input  logic    src_done_i,
  input  logic    snk_done_i,
  output logic    load_en_o,
  output logic    key_load_o,
  output logic    run_o,
  output widx_t   widx_o,
  input  logic    eng_done_i
);

  aes_state_t state_q, state_d;
  widx_t      word_cnt;
  blkcnt_t    blk_cnt;
  blkcnt_t    blk_last;
  logic       rd_done;
  logic       wr_done;
  word_t      base_addr;

  assign rd_done  = (state_q == AES_REQUEST_DATA_WAIT) && src_done_i;
  assign wr_done  = (state_q == AES_SEND_DATA_WAIT) && snk_done_i;
  assign blk_last = nblk_i - 1'b1;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= AES_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Completed transfers, four per block
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      word_cnt <= '0;
    end else if (state_q == AES_STARTING || state_q == AES_WORKING) begin
      word_cnt <= '0;
    end else if (rd_done || wr_done) begin
      word_cnt <= word_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      blk_cnt <= '0;
    end else if (state_q == AES_STARTING) begin
      blk_cnt <= '0;
    end else if (wr_done && word_cnt == 2'd3) begin
      blk_cnt <= blk_cnt + 1'b1;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      AES_IDLE: begin
        if (start_i) begin
          state_d = AES_STARTING;
        end
      end
      // Empty job goes straight to the done event
      AES_STARTING: begin
        state_d = (nblk_i == '0) ? AES_FINISHED : AES_REQUEST_DATA;
      end
      AES_REQUEST_DATA: state_d = AES_REQUEST_DATA_WAIT;
      AES_REQUEST_DATA_WAIT: begin
        if (src_done_i) begin
          state_d = (word_cnt == 2'd3) ? AES_WORKING : AES_REQUEST_DATA;
        end
      end
      AES_WORKING: begin
        if (eng_done_i) begin
          state_d = AES_SEND_DATA;
        end
      end
      AES_SEND_DATA: state_d = AES_SEND_DATA_WAIT;
      AES_SEND_DATA_WAIT: begin
        if (snk_done_i) begin
          if (word_cnt != 2'd3) begin
            state_d = AES_SEND_DATA;
          end else if (blk_cnt == blk_last) begin
            state_d = AES_FINISHED;
          end else begin
            state_d = AES_REQUEST_DATA;
          end
        end
      end
      AES_FINISHED: state_d = AES_IDLE;
      default: state_d = AES_IDLE;
    endcase
  end

  assign busy_o      = (state_q != AES_IDLE);
  assign event_o     = (state_q == AES_FINISHED);
  assign key_load_o  = (state_q == AES_STARTING);
  assign src_start_o = (state_q == AES_REQUEST_DATA);
  assign snk_start_o = (state_q == AES_SEND_DATA);
  assign load_en_o   = rd_done;
  // Cipher starts as the last plaintext word lands in the buffer
  assign run_o       = rd_done && (word_cnt == 2'd3);
  assign widx_o      = word_cnt;

  // Base plus 16 bytes per block plus 4 bytes per word
  assign base_addr   = (state_q == AES_SEND_DATA) ? dst_addr_i : src_addr_i;
  assign xfer_addr_o = base_addr + word_t'({blk_cnt, 4'b0000}) + word_t'({word_cnt, 2'b00});

  // Completions only come back for the one request in flight
  a_one_req: assert property (@(posedge clk) disable iff (!reset_n)
    src_done_i |-> (state_q == AES_REQUEST_DATA_WAIT));

  a_one_snk: assert property (@(posedge clk) disable iff (!reset_n)
    snk_done_i |-> (state_q == AES_SEND_DATA_WAIT));

endmodule

`default_nettype wire

//--- hdl/aes_pkg.sv
`default_nettype none

`include "aes_cfg.svh"

package aes_pkg;

  typedef logic [31:0]               word_t;
  typedef logic [127:0]              block_t;
  typedef logic [`AES_BLKCNT_W-1:0]  blkcnt_t;
  typedef logic [1:0]                widx_t;
  typedef logic [3:0]                round_t;

  typedef enum logic [2:0] {
    AES_IDLE,
    AES_STARTING,
    AES_REQUEST_DATA,
    AES_REQUEST_DATA_WAIT,
    AES_WORKING,
    AES_SEND_DATA,
    AES_SEND_DATA_WAIT,
    AES_FINISHED
  } aes_state_t;

  // Multiply by x in GF(2^8), reduction polynomial 0x11b
  function automatic logic [7:0] aes_xtime(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  // General GF(2^8) product, shift and add
  function automatic logic [7:0] aes_gmul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] acc;
    logic [7:0] sh;
    acc = 8'h00;
    sh  = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        acc = acc ^ sh;
      end
      sh = aes_xtime(sh);
    end
    return acc;
  endfunction

  // S-box from the field inverse b^254 followed by the affine map
  function automatic logic [7:0] aes_sbox(input logic [7:0] b);
    logic [7:0] pw;
    logic [7:0] inv;
    logic [7:0] s;
    pw  = b;
    inv = 8'h01;
    for (int i = 1; i < 8; i++) begin
      pw  = aes_gmul(pw, pw);
      inv = aes_gmul(inv, pw);
    end
    for (int i = 0; i < 8; i++) begin
      s[i] = inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8] ^
             inv[(i + 6) % 8] ^ inv[(i + 7) % 8];
    end
    return s ^ 8'h63;
  endfunction

endpackage

`default_nettype wire

//--- hdl/aes_regfile.sv
`default_nettype none

`include "aes_cfg.svh"

module aes_regfile import aes_pkg::*; (
  input  logic    clk,
  input  logic    reset_n,
  input  logic    reg_we_i,
  input  logic    reg_re_i,
  input  word_t   reg_addr_i,
  input  word_t   reg_wdata_i,
  output word_t   reg_rdata_o,
  input  logic    busy_i,
  output logic    start_o,
  output word_t   src_addr_o,
  output word_t   dst_addr_o,
  output blkcnt_t nblk_o,
  output block_t  key_o
);

  word_t   src_q;
  word_t   dst_q;
  blkcnt_t nblk_q;
  word_t   key_q [4];
  logic    start_q;
  word_t   rdata_q;
  word_t   rd_mux;
  logic    cmd_wr;

  assign cmd_wr = reg_we_i && (reg_addr_i == `AES_REG_CMD);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      src_q  <= '0;
      dst_q  <= '0;
      nblk_q <= '0;
      key_q  <= '{default: '0};
    end else if (reg_we_i) begin
      case (reg_addr_i)
        `AES_REG_SRC:  src_q    <= reg_wdata_i;
        `AES_REG_DST:  dst_q    <= reg_wdata_i;
        `AES_REG_NBLK: nblk_q   <= reg_wdata_i[`AES_BLKCNT_W-1:0];
        `AES_REG_KEY0: key_q[0] <= reg_wdata_i;
        `AES_REG_KEY1: key_q[1] <= reg_wdata_i;
        `AES_REG_KEY2: key_q[2] <= reg_wdata_i;
        `AES_REG_KEY3: key_q[3] <= reg_wdata_i;
        default: ;
      endcase
    end
  end

  // A pending pulse also blocks, since busy only rises a cycle later
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      start_q <= 1'b0;
    end else begin
      start_q <= cmd_wr && reg_wdata_i[0] && !busy_i && !start_q;
    end
  end

  always_comb begin
    case (reg_addr_i)
      `AES_REG_SRC:    rd_mux = src_q;
      `AES_REG_DST:    rd_mux = dst_q;
      `AES_REG_NBLK:   rd_mux = word_t'(nblk_q);
      `AES_REG_KEY0:   rd_mux = key_q[0];
      `AES_REG_KEY1:   rd_mux = key_q[1];
      `AES_REG_KEY2:   rd_mux = key_q[2];
      `AES_REG_KEY3:   rd_mux = key_q[3];
      `AES_REG_STATUS: rd_mux = {31'd0, busy_i};
      default:         rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      rdata_q <= '0;
    end else if (reg_re_i) begin
      rdata_q <= rd_mux;
    end
  end

  assign reg_rdata_o = rdata_q;
  assign start_o     = start_q;
  assign src_addr_o  = src_q;
  assign dst_addr_o  = dst_q;
  assign nblk_o      = nblk_q;
  // KEY0 holds the most significant word
  assign key_o       = {key_q[0], key_q[1], key_q[2], key_q[3]};

  // Start only from idle, and the controller picks it up on the next edge
  a_start_idle: assert property (@(posedge clk) disable iff (!reset_n)
    start_o |-> !busy_i ##1 busy_i);

endmodule

`default_nettype wire

//--- hdl/aes_streamer.sv
`default_nettype none

module aes_streamer import aes_pkg::*; (
  input  logic  clk,
  input  logic  reset_n,
  input  logic  src_start_i,
  input  logic  snk_start_i,
  input  word_t addr_i,
  input  word_t wdata_i,
  output logic  src_done_o,
  output logic  snk_done_o,
  output word_t rdata_o,
  output logic  mem_req_o,
  output logic  mem_we_o,
  output word_t mem_addr_o,
  output word_t mem_wdata_o,
  input  logic  mem_gnt_i,
  input  logic  mem_rvalid_i,
  input  word_t mem_rdata_i
);

  logic  req_q;
  logic  we_q;
  logic  rwait_q;
  word_t addr_q;
  word_t wdata_q;
  logic  granted;

  assign granted = req_q && mem_gnt_i;

  // Request and read wait flags
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      req_q   <= 1'b0;
      we_q    <= 1'b0;
      rwait_q <= 1'b0;
    end else begin
      if (src_start_i || snk_start_i) begin
        req_q <= 1'b1;
        we_q  <= snk_start_i;
      end else if (granted) begin
        req_q <= 1'b0;
      end
      if (granted && !we_q) begin
        rwait_q <= 1'b1;
      end else if (mem_rvalid_i) begin
        rwait_q <= 1'b0;
      end
    end
  end

  // Address and write data held until the grant
  always_ff @(posedge clk) begin
    if (src_start_i || snk_start_i) begin
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
    end
  end

  assign mem_req_o   = req_q;
  assign mem_we_o    = we_q;
  assign mem_addr_o  = addr_q;
  assign mem_wdata_o = wdata_q;

  // Write is done at its grant, a read when rvalid follows
  assign snk_done_o  = granted && we_q;
  assign src_done_o  = rwait_q && mem_rvalid_i;
  assign rdata_o     = mem_rdata_i;

  a_addr_hold: assert property (@(posedge clk) disable iff (!reset_n)
    (mem_req_o && !mem_gnt_i) |=> (mem_req_o && $stable(mem_addr_o)));

endmodule

`default_nettype wire

//--- hdl/aes_top.sv
`default_nettype none

module aes_top import aes_pkg::*; (
  input  logic  clk,
  input  logic  reset_n,
  input  logic  reg_we_i,
  input  logic  reg_re_i,
  input  word_t reg_addr_i,
  input  word_t reg_wdata_i,
  output word_t reg_rdata_o,
  output logic  mem_req_o,
  output logic  mem_we_o,
  output word_t mem_addr_o,
  output word_t mem_wdata_o,
  input  logic  mem_gnt_i,
  input  logic  mem_rvalid_i,
  input  word_t mem_rdata_i,
  output logic  event_o
);

  logic    start;
  logic    busy;
  word_t   src_addr;
  word_t   dst_addr;
  blkcnt_t nblk;
  block_t  key;
  logic    src_start;
  logic    snk_start;
  word_t   xfer_addr;
  logic    src_done;
  logic    snk_done;
  word_t   rd_word;
  logic    load_en;
  logic    key_load;
  logic    run;
  widx_t   widx;
  logic    eng_done;
  word_t   ct_word;

  aes_regfile regfile_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .reg_we_i    (reg_we_i),
    .reg_re_i    (reg_re_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .busy_i      (busy),
    .start_o     (start),
    .src_addr_o  (src_addr),
    .dst_addr_o  (dst_addr),
    .nblk_o      (nblk),
    .key_o       (key)
  );

  aes_fsm fsm_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .start_i     (start),
    .src_addr_i  (src_addr),
    .dst_addr_i  (dst_addr),
    .nblk_i      (nblk),
    .busy_o      (busy),
    .event_o     (event_o),
    .src_start_o (src_start),
    .snk_start_o (snk_start),
    .xfer_addr_o (xfer_addr),
    .src_done_i  (src_done),
    .snk_done_i  (snk_done),
    .load_en_o   (load_en),
    .key_load_o  (key_load),
    .run_o       (run),
    .widx_o      (widx),
    .eng_done_i  (eng_done)
  );

  aes_streamer streamer_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .src_start_i  (src_start),
    .snk_start_i  (snk_start),
    .addr_i       (xfer_addr),
    .wdata_i      (ct_word),
    .src_done_o   (src_done),
    .snk_done_o   (snk_done),
    .rdata_o      (rd_word),
    .mem_req_o    (mem_req_o),
    .mem_we_o     (mem_we_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_gnt_i    (mem_gnt_i),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i)
  );

  // Engine busy is not needed by the controller, which waits on done
  aes_engine engine_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .key_i       (key),
    .key_load_i  (key_load),
    .load_en_i   (load_en),
    .load_idx_i  (widx),
    .load_data_i (rd_word),
    .run_i       (run),
    .done_o      (eng_done),
    .busy_o      (),
    .out_idx_i   (widx),
    .out_word_o  (ct_word)
  );

endmodule

`default_nettype wire

//--- project.f
+incdir+hdl
hdl/aes_pkg.sv
hdl/aes_regfile.sv
hdl/aes_fsm.sv
hdl/aes_streamer.sv
hdl/aes_engine.sv
hdl/aes_top.sv
tests/tb_aes_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the AES accelerator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_aes_top \
  -Mdir obj_dir -o tb_aes_top
if [ $? -ne 0 ]; then
  echo "Verilator build error"
  exit 1
fi

output=$(./obj_dir/tb_aes_top)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Test completed successfully"; then
  exit 0
fi
exit 1

//--- tests/tb_aes_top.sv
`default_nettype none

`include "aes_cfg.svh"

module tb_aes_top import aes_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD  = 8;
  localparam int MEM_WORDS   = 1024;
  localparam int N_RAND_JOBS = 6;
  // Known answer, random jobs, two busy probes, two back-to-back jobs
  localparam int N_JOBS      = 1 + N_RAND_JOBS + 2 + 2;
  localparam int MAX_BLOCKS  = 1 + 8 * N_RAND_JOBS + 16 + 16;
  localparam int WATCHDOG_CYCLES = 200 * MAX_BLOCKS + 300 * N_JOBS + 1000;
  localparam block_t KAT_CT  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

  logic  clk = 1'b0;
  logic  reset_n = 1'b0;
  logic  reg_we = 1'b0;
  logic  reg_re = 1'b0;
  word_t reg_addr = '0;
  word_t reg_wdata = '0;
  word_t reg_rdata;
  logic  mem_req;
  logic  mem_we;
  word_t mem_addr;
  word_t mem_wdata;
  logic  mem_gnt = 1'b0;
  logic  mem_rvalid = 1'b0;
  word_t mem_rdata = '0;
  logic  done_evt;

  integer seed = 37115;
  int     err_cnt = 0;
  int     n_checks = 0;
  int     event_cnt = 0;
  int     bad_addr_cnt = 0;

  // Shared memory and the image it should hold
  word_t mem [MEM_WORDS];
  word_t exp_mem [MEM_WORDS];
  logic [7:0] sbox_tab [256];

  // Job areas for the address checks
  word_t cur_src = '0;
  word_t cur_dst = '0;
  int    cur_nblk = 0;

  // Memory side state
  logic  req_seen = 1'b0;
  int    gnt_wait = 0;
  logic  cap_we = 1'b0;
  word_t cap_addr = '0;
  word_t cap_wdata = '0;

  aes_top dut_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .reg_we_i     (reg_we),
    .reg_re_i     (reg_re),
    .reg_addr_i   (reg_addr),
    .reg_wdata_i  (reg_wdata),
    .reg_rdata_o  (reg_rdata),
    .mem_req_o    (mem_req),
    .mem_we_o     (mem_we),
    .mem_addr_o   (mem_addr),
    .mem_wdata_o  (mem_wdata),
    .mem_gnt_i    (mem_gnt),
    .mem_rvalid_i (mem_rvalid),
    .mem_rdata_i  (mem_rdata),
    .event_o      (done_evt)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic word_t rand_word();
    return $random(seed);
  endfunction

  function automatic bit in_area(input word_t a, input word_t base, input int nblk);
    return (a >= base) && (a < base + word_t'(16 * nblk)) && (a[1:0] == 2'b00);
  endfunction

  // Grant after 0 to 3 idle cycles, read data one cycle after the grant
  always @(negedge clk) begin
    mem_rvalid = 1'b0;
    if (mem_gnt) begin
      mem_gnt = 1'b0;
      if (cap_we) begin
        if (!in_area(cap_addr, cur_dst, cur_nblk)) begin
          $display("Write to address %h lies outside the destination area", cap_addr);
          bad_addr_cnt++;
        end else begin
          mem[cap_addr[11:2]] = cap_wdata;
        end
      end else begin
        if (!in_area(cap_addr, cur_src, cur_nblk)) begin
          $display("Read from address %h lies outside the source area", cap_addr);
          bad_addr_cnt++;
        end
        mem_rvalid = 1'b1;
        mem_rdata  = mem[cap_addr[11:2]];
      end
    end else if (mem_req) begin
      if (!req_seen) begin
        req_seen = 1'b1;
        gnt_wait = int'(rand_word() & 32'd3);
      end
      if (gnt_wait == 0) begin
        mem_gnt   = 1'b1;
        req_seen  = 1'b0;
        cap_we    = mem_we;
        cap_addr  = mem_addr;
        cap_wdata = mem_wdata;
      end else begin
        gnt_wait--;
      end
    end
  end

  always @(negedge clk) begin
    if (done_evt) begin
      event_cnt++;
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the DUT stopped responding",
             WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

  task automatic check_value(input string name, input word_t got, input word_t exp);
    n_checks++;
    if (got !== exp) begin
      err_cnt++;
      $display("FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    if (err_cnt == err_start) begin
      $display("[%0t] %s: ok", $time, name);
    end else begin
      $display("[%0t] %s: %0d errors", $time, name, err_cnt - err_start);
    end
  endtask

  function automatic logic [7:0] gf_double(input logic [7:0] v);
    return {v[6:0], 1'b0} ^ (v[7] ? 8'h1b : 8'h00);
  endfunction

  // S-box from log and antilog tables over generator 3
  task automatic build_sbox();
    logic [7:0] exp_t [256];
    logic [7:0] log_t [256];
    logic [7:0] p;
    logic [7:0] inv;
    p = 8'h01;
    for (int i = 0; i < 255; i++) begin
      exp_t[i] = p;
      log_t[p] = 8'(i);
      p = p ^ gf_double(p);
    end
    for (int b = 0; b < 256; b++) begin
      inv = (b == 0) ? 8'h00 : exp_t[(255 - int'(log_t[b])) % 255];
      sbox_tab[b] = inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^
                    {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
    end
  endtask

  // Straight AES-128 with the full key schedule expanded first
  function automatic block_t aes_model(input block_t key, input block_t pt);
    word_t      w [44];
    word_t      t;
    logic [7:0] rc;
    logic [7:0] s [16];
    logic [7:0] u [16];
    logic [7:0] a0;
    logic [7:0] a1;
    logic [7:0] a2;
    logic [7:0] a3;
    block_t     rk;
    block_t     res;
    rc = 8'h01;
    for (int i = 0; i < 4; i++) begin
      w[i] = key[127 - 32 * i -: 32];
    end
    for (int i = 4; i < 44; i++) begin
      t = w[i - 1];
      if (i % 4 == 0) begin
        t = {sbox_tab[t[23:16]], sbox_tab[t[15:8]], sbox_tab[t[7:0]], sbox_tab[t[31:24]]} ^
            {rc, 24'd0};
        rc = gf_double(rc);
      end
      w[i] = w[i - 4] ^ t;
    end
    for (int n = 0; n < 16; n++) begin
      s[n] = pt[127 - 8 * n -: 8] ^ key[127 - 8 * n -: 8];
    end
    for (int r = 1; r <= 10; r++) begin
      rk = {w[4 * r], w[4 * r + 1], w[4 * r + 2], w[4 * r + 3]};
      for (int c = 0; c < 4; c++) begin
        for (int row = 0; row < 4; row++) begin
          u[4 * c + row] = sbox_tab[s[4 * ((c + row) % 4) + row]];
        end
      end
      for (int c = 0; c < 4; c++) begin
        a0 = u[4 * c];
        a1 = u[4 * c + 1];
        a2 = u[4 * c + 2];
        a3 = u[4 * c + 3];
        if (r < 10) begin
          s[4 * c]     = gf_double(a0) ^ gf_double(a1) ^ a1 ^ a2 ^ a3;
          s[4 * c + 1] = a0 ^ gf_double(a1) ^ gf_double(a2) ^ a2 ^ a3;
          s[4 * c + 2] = a0 ^ a1 ^ gf_double(a2) ^ gf_double(a3) ^ a3;
          s[4 * c + 3] = gf_double(a0) ^ a0 ^ a1 ^ a2 ^ gf_double(a3);
        end else begin
          s[4 * c]     = a0;
          s[4 * c + 1] = a1;
          s[4 * c + 2] = a2;
          s[4 * c + 3] = a3;
        end
      end
      for (int n = 0; n < 16; n++) begin
        s[n] = s[n] ^ rk[127 - 8 * n -: 8];
      end
    end
    for (int n = 0; n < 16; n++) begin
      res[127 - 8 * n -: 8] = s[n];
    end
    return res;
  endfunction

  task automatic reg_write(input word_t addr, input word_t data);
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_we = 1'b0;
  endtask

  task automatic reg_read(input word_t addr, output word_t data);
    reg_re   = 1'b1;
    reg_addr = addr;
    @(negedge clk);
    reg_re = 1'b0;
    data   = reg_rdata;
  endtask

  task automatic fill_source(input word_t src, input int nblk);
    word_t v;
    for (int i = 0; i < 4 * nblk; i++) begin
      v = rand_word();
      mem[(src >> 2) + word_t'(i)]     = v;
      exp_mem[(src >> 2) + word_t'(i)] = v;
    end
  endtask

  // Programs one job, runs it and compares the whole memory afterwards
  task automatic run_job(input word_t src, input word_t dst, input int nblk,
                         input block_t key, input bit probe);
    word_t  rd;
    int     ev_before;
    int     bad_before;
    int     s_idx;
    int     d_idx;
    block_t pt;
    block_t ct;
    cur_src  = src;
    cur_dst  = dst;
    cur_nblk = nblk;
    reg_write(`AES_REG_SRC, src);
    reg_write(`AES_REG_DST, dst);
    reg_write(`AES_REG_NBLK, word_t'(nblk));
    reg_write(`AES_REG_KEY0, key[127:96]);
    reg_write(`AES_REG_KEY1, key[95:64]);
    reg_write(`AES_REG_KEY2, key[63:32]);
    reg_write(`AES_REG_KEY3, key[31:0]);
    s_idx = int'(src >> 2);
    d_idx = int'(dst >> 2);
    for (int b = 0; b < nblk; b++) begin
      pt = {exp_mem[s_idx + 4 * b], exp_mem[s_idx + 4 * b + 1],
            exp_mem[s_idx + 4 * b + 2], exp_mem[s_idx + 4 * b + 3]};
      ct = aes_model(key, pt);
      for (int k = 0; k < 4; k++) begin
        exp_mem[d_idx + 4 * b + k] = ct[127 - 32 * k -: 32];
      end
    end
    ev_before  = event_cnt;
    bad_before = bad_addr_cnt;
    reg_write(`AES_REG_CMD, 32'd1);
    @(negedge clk);
    if (probe) begin
      reg_read(`AES_REG_STATUS, rd);
      check_value("status_busy", rd, 32'd1);
      // Second start while running must be dropped
      reg_write(`AES_REG_CMD, 32'd1);
    end
    while (done_evt !== 1'b1) begin
      @(negedge clk);
    end
    if (probe) begin
      // Start in the done cycle, busy is still high and the machine is about to idle
      reg_write(`AES_REG_CMD, 32'd1);
    end
    // Let the last write land in memory
    @(negedge clk);
    if (probe) begin
      reg_read(`AES_REG_STATUS, rd);
      check_value("status_busy", rd, 32'd0);
      check_value("event_count", word_t'(event_cnt - ev_before), 32'd1);
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      check_value($sformatf("mem[%0d]", i), mem[i], exp_mem[i]);
    end
    check_value("bad_addr_count", word_t'(bad_addr_cnt - bad_before), 32'd0);
  endtask

  task automatic check_known_answer();
    block_t key;
    block_t pt;
    block_t ct;
    word_t  src;
    word_t  dst;
    int     err_start;
    err_start = err_cnt;
    key = 128'h000102030405060708090a0b0c0d0e0f;
    pt  = 128'h00112233445566778899aabbccddeeff;
    src = 32'h100;
    dst = 32'h900;
    ct  = aes_model(key, pt);
    for (int k = 0; k < 4; k++) begin
      check_value("model_ct", ct[127 - 32 * k -: 32], KAT_CT[127 - 32 * k -: 32]);
      mem[(src >> 2) + word_t'(k)]     = pt[127 - 32 * k -: 32];
      exp_mem[(src >> 2) + word_t'(k)] = pt[127 - 32 * k -: 32];
    end
    run_job(src, dst, 1, key, 1'b1);
    for (int k = 0; k < 4; k++) begin
      check_value("dst_ct", mem[(dst >> 2) + word_t'(k)], KAT_CT[127 - 32 * k -: 32]);
    end
    report_test("known_answer", err_start);
  endtask

  task automatic check_registers();
    word_t addrs [7];
    string names [7];
    word_t vals [7];
    word_t rd;
    word_t exp;
    int    err_start;
    err_start = err_cnt;
    addrs = '{`AES_REG_SRC, `AES_REG_DST, `AES_REG_NBLK, `AES_REG_KEY0,
              `AES_REG_KEY1, `AES_REG_KEY2, `AES_REG_KEY3};
    names = '{"SRC", "DST", "NBLK", "KEY0", "KEY1", "KEY2", "KEY3"};
    for (int i = 0; i < 7; i++) begin
      vals[i] = rand_word();
      reg_write(addrs[i], vals[i]);
    end
    for (int i = 0; i < 7; i++) begin
      reg_read(addrs[i], rd);
      exp = vals[i];
      // Only the block count width is stored
      if (addrs[i] == `AES_REG_NBLK) begin
        exp = vals[i] & ((word_t'(1) << `AES_BLKCNT_W) - 32'd1);
      end
      check_value(names[i], rd, exp);
    end
    reg_read(`AES_REG_STATUS, rd);
    check_value("STATUS", rd, 32'd0);
    report_test("register_readback", err_start);
  endtask

  task automatic run_random_jobs();
    word_t  src;
    word_t  dst;
    int     nblk;
    block_t key;
    int     err_start;
    err_start = err_cnt;
    for (int j = 0; j < N_RAND_JOBS; j++) begin
      src  = (rand_word() % 32'd96) * 32'd16;
      dst  = 32'h800 + (rand_word() % 32'd96) * 32'd16;
      nblk = 1 + int'(rand_word() % 32'd8);
      key  = {rand_word(), rand_word(), rand_word(), rand_word()};
      fill_source(src, nblk);
      run_job(src, dst, nblk, key, 1'b0);
    end
    report_test("random_jobs_and_bounds", err_start);
  endtask

  task automatic check_busy_start();
    word_t  src;
    word_t  dst;
    int     nblk;
    int     err_start;
    err_start = err_cnt;
    for (int j = 0; j < 2; j++) begin
      src  = 32'h200 + 32'h100 * word_t'(j);
      dst  = 32'hc00 + 32'h100 * word_t'(j);
      nblk = 1 + int'(rand_word() % 32'd8);
      fill_source(src, nblk);
      run_job(src, dst, nblk, {rand_word(), rand_word(), rand_word(), rand_word()}, 1'b1);
    end
    report_test("start_while_busy", err_start);
  endtask

  // Second job is programmed as soon as the first one signals done
  task automatic run_back_to_back();
    int err_start;
    err_start = err_cnt;
    fill_source(32'h000, 8);
    fill_source(32'h400, 8);
    run_job(32'h000, 32'ha00, 8, {rand_word(), rand_word(), rand_word(), rand_word()}, 1'b0);
    run_job(32'h400, 32'hb00, 8, {rand_word(), rand_word(), rand_word(), rand_word()}, 1'b0);
    report_test("back_to_back", err_start);
  endtask

  initial begin
    int err_start;
    build_sbox();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i]     = (word_t'(i) * 32'h9e3779b1) ^ 32'hc3a50000;
      exp_mem[i] = mem[i];
    end
    reset_n = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
    err_start = err_cnt;
    check_value("mem_req_o", word_t'(mem_req), 32'd0);
    check_value("event_o", word_t'(done_evt), 32'd0);
    report_test("reset", err_start);
    check_known_answer();
    check_registers();
    run_random_jobs();
    check_busy_start();
    run_back_to_back();
    $display("checks: %0d, errors: %0d", n_checks, err_cnt);
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
